/* src/cpc_io_pkg.sv */
`default_nettype none

// ===========================================================================
// CPU I/O map and command queue constants
// ===========================================================================
package cpc_io_pkg;

  // Port bus widths
  localparam int IO_ADDR_W = 16;  // Z80 style 16-bit port address
  localparam int IO_DATA_W = 8;

  // Upper address byte of each PPI port
  localparam logic [7:0] PPI_A_PAGE    = 8'hF4;
  localparam logic [7:0] PPI_C_PAGE    = 8'hF6;  // F5 is PPI B, not decoded here
  localparam logic [7:0] PPI_CTRL_PAGE = 8'hF7;

  // Command queue sizing
  localparam int QUEUE_DEPTH = 4;                      // Power of two
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);    // Pointers wrap by themselves
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Where a decoded write goes
  typedef enum logic [2:0] {
    GA       = 3'd0,  // Gate array, A15..A14 == 01
    ROM_BANK = 3'd1,  // Upper ROM select, A13 low
    PPI_A    = 3'd2,
    PPI_C    = 3'd3,
    PPI_CTRL = 3'd4
  } io_target_e;

endpackage

`default_nettype wire

/* src/cpc_ga_pkg.sv */
`default_nettype none

// ===========================================================================
// Gate array fields, functions and read sources
// ===========================================================================
package cpc_ga_pkg;

  // Register field widths
  localparam int PEN_W      = 4;
  localparam int PEN_COUNT  = 16;  // Palette entries
  localparam int COLOR_W    = 5;   // Hardware colour number
  localparam int BANK_W     = 3;   // RAM bank and RAM config
  localparam int ROM_BANK_W = 4;

  // CPU clock enable every 2**(CPU_SPEED+1) cycles
  localparam int CPU_SPEED = 2;

  // Gate array function, data bits 7..6
  typedef enum logic [1:0] {
    PEN_SELECT = 2'd0,
    INK_WRITE  = 2'd1,
    MODE_ROM   = 2'd2,  // Mode, ROM disables, int clear
    RAM_CONFIG = 2'd3
  } ga_func_e;

  typedef enum logic [1:0] {
    MODE_0 = 2'd0,  // 160 x 200, 16 colours
    MODE_1 = 2'd1,
    MODE_2 = 2'd2,  // 640 x 200, 2 colours
    MODE_3 = 2'd3
  } video_mode_e;

  // Who answers a memory read
  typedef enum logic [1:0] {
    RAM  = 2'd0,
    ROM  = 2'd1,
    VRAM = 2'd2  // Top 16K when upper ROM is off
  } read_source_e;

endpackage

`default_nettype wire

/* src/io_cmd_if.sv */
`default_nettype none

// Decoded I/O write command, valid/ready handshake
// Payload holds steady from valid until the transfer edge
interface io_cmd_if;

  logic                                valid;
  logic                                ready;
  cpc_io_pkg::io_target_e              target;
  logic [cpc_io_pkg::IO_DATA_W-1:0]    data;
  logic                                sel;    // A4, border select for GA

  modport source (
    output valid,
    output target,
    output data,
    output sel,
    input  ready
  );

  modport sink (
    input  valid,
    input  target,
    input  data,
    input  sel,
    output ready
  );

endinterface

`default_nettype wire

/* src/apb_io_decoder.sv */
`default_nettype none

module apb_io_decoder (
  input  wire                                 clk_cpu,
  input  wire                                 pwr_up_reset_n,
  // APB completer
  input  wire                                 i_psel,
  input  wire                                 i_penable,
  input  wire                                 i_pwrite,
  input  wire [cpc_io_pkg::IO_ADDR_W-1:0]     i_paddr,
  input  wire [cpc_io_pkg::IO_DATA_W-1:0]     i_pwdata,
  output logic                                o_pready,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]    o_prdata,
  output logic                                o_pslverr,
  // Queue state and readback values
  input  wire                                 i_empty,
  input  wire [cpc_io_pkg::IO_DATA_W-1:0]     i_ppi_a,
  input  wire [cpc_io_pkg::IO_DATA_W-1:0]     i_ppi_c,
  input  wire [cpc_io_pkg::IO_DATA_W-1:0]     i_ppi_ctrl,
  io_cmd_if.source                            cmd
);

  logic                    access;      // APB access phase
  logic [7:0]              page;        // Upper address byte
  logic                    has_target;  // Write lands somewhere
  cpc_io_pkg::io_target_e  target;
  logic                    slot_free;   // Command slot empty or leaving
  logic                    wr_accept;

  assign access    = i_psel & i_penable;
  assign page      = i_paddr[15:8];
  assign slot_free = ~cmd.valid | cmd.ready;
  assign wr_accept = access & i_pwrite & has_target & slot_free;
  assign o_pslverr = 1'b0;

  // =========================================================================
  // Port decode, same priority as the gate array chip selects
  // =========================================================================
  always_comb begin
    has_target = 1'b1;
    target     = cpc_io_pkg::GA;
    if (i_paddr[15:14] == 2'b01) begin
      target = cpc_io_pkg::GA;
    end else if (!i_paddr[13]) begin
      target = cpc_io_pkg::ROM_BANK;
    end else begin
      case (page)
        cpc_io_pkg::PPI_A_PAGE:    target = cpc_io_pkg::PPI_A;
        cpc_io_pkg::PPI_C_PAGE:    target = cpc_io_pkg::PPI_C;
        cpc_io_pkg::PPI_CTRL_PAGE: target = cpc_io_pkg::PPI_CTRL;
        default:                   has_target = 1'b0;  // Ignored, still completes
      endcase
    end
  end

  // Writes wait for a slot, reads wait for the whole path to drain
  always_comb begin
    if (i_pwrite) begin
      o_pready = access & (slot_free | ~has_target);
    end else begin
      o_pready = access & i_empty & ~cmd.valid;
    end
  end

  // Readback, PPI registers only
  always_comb begin
    case (page)
      cpc_io_pkg::PPI_A_PAGE:    o_prdata = i_ppi_a;
      cpc_io_pkg::PPI_C_PAGE:    o_prdata = i_ppi_c;
      cpc_io_pkg::PPI_CTRL_PAGE: o_prdata = i_ppi_ctrl;
      default:                   o_prdata = '0;
    endcase
  end

  // =========================================================================
  // Command slot
  // =========================================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      cmd.valid <= 1'b0;
    end else if (wr_accept) begin
      cmd.valid <= 1'b1;   // New command, old one gone this edge
    end else if (cmd.ready) begin
      cmd.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (wr_accept) begin
      cmd.target <= target;
      cmd.data   <= i_pwdata;
      cmd.sel    <= i_paddr[4];  // Border flag
    end
  end

endmodule

`default_nettype wire

/* src/io_cmd_queue.sv */
`default_nettype none

module io_cmd_queue (
  input  wire       clk_cpu,
  input  wire       pwr_up_reset_n,
  output logic      o_empty,     // FIFO and output stage both idle
  io_cmd_if.sink    in_cmd,
  io_cmd_if.source  out_cmd
);

  typedef struct packed {
    cpc_io_pkg::io_target_e              target;
    logic                                sel;
    logic [cpc_io_pkg::IO_DATA_W-1:0]    data;
  } entry_t;

  entry_t                              mem [cpc_io_pkg::QUEUE_DEPTH];
  logic [cpc_io_pkg::QUEUE_PTR_W-1:0]  wr_ptr;
  logic [cpc_io_pkg::QUEUE_PTR_W-1:0]  rd_ptr;
  logic [cpc_io_pkg::QUEUE_CNT_W-1:0]  count;
  logic                                push;
  logic                                stage_free;  // Output stage can load
  logic                                pop;         // FIFO head to stage
  logic                                bypass;      // Straight into stage

  assign in_cmd.ready = (count != cpc_io_pkg::QUEUE_CNT_W'(cpc_io_pkg::QUEUE_DEPTH));
  assign push         = in_cmd.valid & in_cmd.ready;
  assign stage_free   = ~out_cmd.valid | out_cmd.ready;
  assign pop          = stage_free & (count != '0);
  assign bypass       = push & stage_free & (count == '0);
  assign o_empty      = (count == '0) & ~out_cmd.valid;

  // Pointers and occupancy
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push && !bypass) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + ((push && !bypass) ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (push && !bypass) mem[wr_ptr] <= '{in_cmd.target, in_cmd.sel, in_cmd.data};
  end

  // Registered output stage
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      out_cmd.valid <= 1'b0;
    end else if (stage_free) begin
      out_cmd.valid <= pop | bypass;
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (pop) begin
      out_cmd.target <= mem[rd_ptr].target;
      out_cmd.sel    <= mem[rd_ptr].sel;
      out_cmd.data   <= mem[rd_ptr].data;
    end else if (bypass) begin
      out_cmd.target <= in_cmd.target;
      out_cmd.sel    <= in_cmd.sel;
      out_cmd.data   <= in_cmd.data;
    end
  end

endmodule

`default_nettype wire

/* src/gate_array_regs.sv */
`default_nettype none

module gate_array_regs (
  input  wire                                     clk_cpu,
  input  wire                                     pwr_up_reset_n,
  io_cmd_if.sink                                  cmd,
  // Palette and memory queries
  input  wire [cpc_ga_pkg::PEN_W-1:0]             i_pen,
  input  wire [1:0]                               i_mem_page,  // A15..A14
  output logic [cpc_ga_pkg::COLOR_W-1:0]          o_color,
  output logic [cpc_ga_pkg::COLOR_W-1:0]          o_border_color,
  output cpc_ga_pkg::video_mode_e                 o_mode,
  output logic                                    o_hi_rom_disable,
  output logic                                    o_lo_rom_disable,
  output logic [cpc_ga_pkg::BANK_W-1:0]           o_ram_bank,
  output logic [cpc_ga_pkg::BANK_W-1:0]           o_ram_config,
  output logic [cpc_ga_pkg::ROM_BANK_W-1:0]       o_rom_bank,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]        o_ppi_a,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]        o_ppi_c,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]        o_ppi_ctrl,
  output logic                                    o_int_clear,
  output cpc_ga_pkg::read_source_e                o_read_source
);

  logic [cpc_ga_pkg::CPU_SPEED:0]     presc_cnt;
  logic                               cpu_strobe;
  logic                               apply;
  cpc_ga_pkg::ga_func_e               ga_func;
  logic [cpc_ga_pkg::PEN_W-1:0]       pen;
  logic                               border_sel;
  logic [cpc_ga_pkg::COLOR_W-1:0]     palette [cpc_ga_pkg::PEN_COUNT];

  // =========================================================================
  // CPU clock enable, one cycle in 2**(CPU_SPEED+1)
  // =========================================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) presc_cnt <= '0;
    else presc_cnt <= presc_cnt + 1'b1;
  end

  assign cpu_strobe = &presc_cnt;
  assign cmd.ready  = cpu_strobe;  // Commands only land on the strobe
  assign apply      = cmd.valid & cpu_strobe;
  assign ga_func    = cpc_ga_pkg::ga_func_e'(cmd.data[7:6]);

  // Interrupt clear rides along with a MODE_ROM write, D4 set
  assign o_int_clear = apply & (cmd.target == cpc_io_pkg::GA) &
                       (ga_func == cpc_ga_pkg::MODE_ROM) & cmd.data[4];

  // =========================================================================
  // Command execution
  // =========================================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      pen              <= '0;
      border_sel       <= 1'b0;
      o_border_color   <= '0;
      o_mode           <= cpc_ga_pkg::MODE_0;
      o_hi_rom_disable <= 1'b0;  // Both ROMs on at power up
      o_lo_rom_disable <= 1'b0;
      o_ram_bank       <= '0;
      o_ram_config     <= '0;
      o_rom_bank       <= '0;
      o_ppi_a          <= '0;
      o_ppi_c          <= '0;
      o_ppi_ctrl       <= '0;
      for (int i = 0; i < cpc_ga_pkg::PEN_COUNT; i++) palette[i] <= '0;
    end else if (apply) begin
      case (cmd.target)
        cpc_io_pkg::GA: begin
          case (ga_func)
            cpc_ga_pkg::PEN_SELECT: begin
              border_sel <= cmd.sel;
              if (!cmd.data[4]) pen <= cmd.data[cpc_ga_pkg::PEN_W-1:0];  // D4 keeps pen
            end
            cpc_ga_pkg::INK_WRITE: begin
              if (border_sel) o_border_color <= cmd.data[cpc_ga_pkg::COLOR_W-1:0];
              else palette[pen] <= cmd.data[cpc_ga_pkg::COLOR_W-1:0];
            end
            cpc_ga_pkg::MODE_ROM: begin
              o_hi_rom_disable <= cmd.data[3];
              o_lo_rom_disable <= cmd.data[2];
              o_mode           <= cpc_ga_pkg::video_mode_e'(cmd.data[1:0]);
            end
            cpc_ga_pkg::RAM_CONFIG: begin
              o_ram_bank   <= cmd.data[2*cpc_ga_pkg::BANK_W-1:cpc_ga_pkg::BANK_W];
              o_ram_config <= cmd.data[cpc_ga_pkg::BANK_W-1:0];
            end
            default: ;
          endcase
        end
        cpc_io_pkg::ROM_BANK: o_rom_bank <= cmd.data[cpc_ga_pkg::ROM_BANK_W-1:0];
        cpc_io_pkg::PPI_A:    o_ppi_a    <= cmd.data;
        cpc_io_pkg::PPI_C:    o_ppi_c    <= cmd.data;
        cpc_io_pkg::PPI_CTRL: o_ppi_ctrl <= cmd.data;
        default: ;  // Unused encodings
      endcase
    end
  end

  // =========================================================================
  // Lookups
  // =========================================================================
  assign o_color = palette[i_pen];

  // Lower ROM at page 0, upper ROM over video RAM at page 3
  always_comb begin
    case (i_mem_page)
      2'd0:    o_read_source = o_lo_rom_disable ? cpc_ga_pkg::RAM : cpc_ga_pkg::ROM;
      2'd3:    o_read_source = o_hi_rom_disable ? cpc_ga_pkg::VRAM : cpc_ga_pkg::ROM;
      default: o_read_source = cpc_ga_pkg::RAM;
    endcase
  end

endmodule

`default_nettype wire

/* src/cpc_io_top.sv */
`default_nettype none

module cpc_io_top (
  input  wire                                     clk_cpu,
  input  wire                                     pwr_up_reset_n,
  // APB from the CPU I/O side
  input  wire                                     i_psel,
  input  wire                                     i_penable,
  input  wire                                     i_pwrite,
  input  wire [cpc_io_pkg::IO_ADDR_W-1:0]         i_paddr,
  input  wire [cpc_io_pkg::IO_DATA_W-1:0]         i_pwdata,
  output logic                                    o_pready,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]        o_prdata,
  output logic                                    o_pslverr,
  // Gate array state
  input  wire [cpc_ga_pkg::PEN_W-1:0]             i_pen,
  input  wire [1:0]                               i_mem_page,
  output logic [cpc_ga_pkg::COLOR_W-1:0]          o_color,
  output logic [cpc_ga_pkg::COLOR_W-1:0]          o_border_color,
  output cpc_ga_pkg::video_mode_e                 o_mode,
  output logic                                    o_hi_rom_disable,
  output logic                                    o_lo_rom_disable,
  output logic [cpc_ga_pkg::BANK_W-1:0]           o_ram_bank,
  output logic [cpc_ga_pkg::BANK_W-1:0]           o_ram_config,
  output logic [cpc_ga_pkg::ROM_BANK_W-1:0]       o_rom_bank,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]        o_ppi_a,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]        o_ppi_c,
  output logic [cpc_io_pkg::IO_DATA_W-1:0]        o_ppi_ctrl,
  output logic                                    o_int_clear,
  output cpc_ga_pkg::read_source_e                o_read_source
);

  logic queue_empty;

  io_cmd_if dec_cmd ();  // Decoder to queue
  io_cmd_if ga_cmd ();   // Queue to register block

  apb_io_decoder apb_io_decoder_i (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .o_pready       (o_pready),
    .o_prdata       (o_prdata),
    .o_pslverr      (o_pslverr),
    .i_empty        (queue_empty),
    .i_ppi_a        (o_ppi_a),     // Readback straight from the registers
    .i_ppi_c        (o_ppi_c),
    .i_ppi_ctrl     (o_ppi_ctrl),
    .cmd            (dec_cmd.source)
  );

  io_cmd_queue io_cmd_queue_i (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .o_empty        (queue_empty),
    .in_cmd         (dec_cmd.sink),
    .out_cmd        (ga_cmd.source)
  );

  gate_array_regs gate_array_regs_i (
    .clk_cpu          (clk_cpu),
    .pwr_up_reset_n   (pwr_up_reset_n),
    .cmd              (ga_cmd.sink),
    .i_pen            (i_pen),
    .i_mem_page       (i_mem_page),
    .o_color          (o_color),
    .o_border_color   (o_border_color),
    .o_mode           (o_mode),
    .o_hi_rom_disable (o_hi_rom_disable),
    .o_lo_rom_disable (o_lo_rom_disable),
    .o_ram_bank       (o_ram_bank),
    .o_ram_config     (o_ram_config),
    .o_rom_bank       (o_rom_bank),
    .o_ppi_a          (o_ppi_a),
    .o_ppi_c          (o_ppi_c),
    .o_ppi_ctrl       (o_ppi_ctrl),
    .o_int_clear      (o_int_clear),
    .o_read_source    (o_read_source)
  );

endmodule

`default_nettype wire

/* dv/cpc_io_assertions.sv */
`default_nettype none

module cpc_io_assertions (
  input wire        clk_cpu,
  input wire        pwr_up_reset_n,
  input wire        i_psel,
  input wire        i_penable,
  input wire        i_pwrite,
  input wire [15:0] i_paddr,
  input wire [7:0]  i_pwdata,
  input wire        o_pready,
  input wire [7:0]  o_prdata,
  input wire        o_pslverr,
  input wire [3:0]  i_pen,
  input wire [1:0]  i_mem_page,
  input wire [4:0]  o_color,
  input wire [4:0]  o_border_color,
  input wire [1:0]  o_mode,
  input wire        o_hi_rom_disable,
  input wire        o_lo_rom_disable,
  input wire [2:0]  o_ram_bank,
  input wire [2:0]  o_ram_config,
  input wire [3:0]  o_rom_bank,
  input wire [7:0]  o_ppi_a,
  input wire [7:0]  o_ppi_c,
  input wire [7:0]  o_ppi_ctrl,
  input wire        o_int_clear,
  input wire [1:0]  o_read_source,
  input wire        queue_empty
);

  int         fail_count = 0;  // Read by the testbench at the end
  logic       wr_done, rd_done, idle, just_wrote, int_req;
  logic [7:0] exp_rdata;
  logic [3:0] m_pen, m_rom;
  logic       m_border, m_hi, m_lo;
  logic [4:0] m_bcol;
  logic [4:0] m_pal [16];
  logic [1:0] m_mode, exp_src;
  logic [2:0] m_bank, m_cfg;
  logic [7:0] m_ppi_a, m_ppi_c, m_ppi_ctrl;
  int         m_int;           // Interrupt clears still owed

  assign wr_done = i_psel & i_penable & i_pwrite & o_pready;
  assign rd_done = i_psel & i_penable & ~i_pwrite & o_pready;
  assign idle    = queue_empty & ~just_wrote;  // Decoder slot counted too
  assign int_req = wr_done & (i_paddr[15:14] == 2'b01) & (i_pwdata[7:6] == 2'd2) & i_pwdata[4];

  always_comb begin
    case (i_paddr[15:8])
      8'hF4:   exp_rdata = m_ppi_a;
      8'hF6:   exp_rdata = m_ppi_c;
      8'hF7:   exp_rdata = m_ppi_ctrl;
      default: exp_rdata = 8'h00;
    endcase
    case (i_mem_page)
      2'd0:    exp_src = m_lo ? 2'd0 : 2'd1;  // RAM or ROM
      2'd3:    exp_src = m_hi ? 2'd2 : 2'd1;  // VRAM or ROM
      default: exp_src = 2'd0;
    endcase
  end

  // ==========================================================================
  // Register model, updated at write completion
  // ==========================================================================
  always @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      {m_pen, m_rom, m_border, m_hi, m_lo, m_bcol, m_mode, m_bank, m_cfg} <= '0;
      {m_ppi_a, m_ppi_c, m_ppi_ctrl} <= '0;
      for (int i = 0; i < 16; i++) m_pal[i] <= '0;
      m_int      <= 0;
      just_wrote <= 1'b0;
    end else begin
      just_wrote <= wr_done;
      m_int      <= m_int + (int_req ? 1 : 0) - (o_int_clear ? 1 : 0);
      if (wr_done) begin
        if (i_paddr[15:14] == 2'b01) begin
          case (i_pwdata[7:6])
            2'd0: begin
              m_border <= i_paddr[4];
              if (!i_pwdata[4]) m_pen <= i_pwdata[3:0];
            end
            2'd1: begin
              if (m_border) m_bcol <= i_pwdata[4:0];
              else m_pal[m_pen] <= i_pwdata[4:0];
            end
            2'd2: {m_hi, m_lo, m_mode} <= i_pwdata[3:0];
            default: {m_bank, m_cfg} <= i_pwdata[5:0];
          endcase
        end else if (!i_paddr[13]) begin
          m_rom <= i_pwdata[3:0];
        end else begin
          case (i_paddr[15:8])
            8'hF4: m_ppi_a <= i_pwdata;
            8'hF6: m_ppi_c <= i_pwdata;
            8'hF7: m_ppi_ctrl <= i_pwdata;
            default: ;  // Unmapped, dropped
          endcase
        end
      end
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================
  a_bus: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    !o_pslverr && (!o_pready || (i_psel && i_penable)))
    else begin $error("pready outside an access or pslverr set"); fail_count++; end
  a_read: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    rd_done |-> o_prdata == exp_rdata)
    else begin $error("Error o_prdata %h expected %h", o_prdata, exp_rdata); fail_count++; end
  a_ppi: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    idle |-> {o_ppi_a, o_ppi_c, o_ppi_ctrl} == {m_ppi_a, m_ppi_c, m_ppi_ctrl})
    else begin $error("Error o_ppi_a/c/ctrl %h expected %h",
      {o_ppi_a, o_ppi_c, o_ppi_ctrl}, {m_ppi_a, m_ppi_c, m_ppi_ctrl}); fail_count++; end
  a_color: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    idle |-> o_color == m_pal[i_pen] && o_border_color == m_bcol)
    else begin $error("Error o_color/o_border_color %h %h expected %h %h",
      o_color, o_border_color, m_pal[i_pen], m_bcol); fail_count++; end
  a_mode: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    idle |-> {o_hi_rom_disable, o_lo_rom_disable, o_mode} == {m_hi, m_lo, m_mode}
             && o_read_source == exp_src)
    else begin $error("Error o_mode/disables/o_read_source %h %h expected %h %h",
      {o_hi_rom_disable, o_lo_rom_disable, o_mode}, o_read_source,
      {m_hi, m_lo, m_mode}, exp_src); fail_count++; end
  a_banks: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    idle |-> {o_rom_bank, o_ram_bank, o_ram_config} == {m_rom, m_bank, m_cfg})
    else begin $error("Error o_rom_bank/o_ram_bank/o_ram_config %h expected %h",
      {o_rom_bank, o_ram_bank, o_ram_config}, {m_rom, m_bank, m_cfg}); fail_count++; end
  a_int: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    (!o_int_clear || m_int > 0) && (!idle || m_int == 0))
    else begin $error("Interrupt clear pulse missing or unexpected"); fail_count++; end

endmodule

bind cpc_io_top cpc_io_assertions cpc_io_assertions_i (.*);

`default_nettype wire

/* dv/cpc_io_tb.sv */
`default_nettype none

module cpc_io_tb;

  localparam int ACCESS_CYCLES   = 8 * (cpc_io_pkg::QUEUE_DEPTH + 2) + 4;  // Worst stall
  localparam int ACCESS_COUNT    = 105;
  localparam int SWEEP_CYCLES    = 400;  // Pen and page sweeps
  localparam int WATCHDOG_CYCLES = 2 * (ACCESS_COUNT * ACCESS_CYCLES + SWEEP_CYCLES);

  logic        clk_cpu = 1'b0;
  logic        pwr_up_reset_n;
  logic        i_psel, i_penable, i_pwrite;
  logic [15:0] i_paddr;
  logic [7:0]  i_pwdata, o_prdata, o_ppi_a, o_ppi_c, o_ppi_ctrl;
  logic        o_pready, o_pslverr, o_hi_rom_disable, o_lo_rom_disable, o_int_clear;
  logic [3:0]  i_pen, o_rom_bank;
  logic [1:0]  i_mem_page;
  logic [4:0]  o_color, o_border_color;
  logic [2:0]  o_ram_bank, o_ram_config;
  cpc_ga_pkg::video_mode_e  o_mode;
  cpc_ga_pkg::read_source_e o_read_source;

  logic [31:0] lfsr = 32'd98059;
  int          stall_errors = 0;
  int          tests_done = 0;
  logic [15:0] r, r2;

  always #4 clk_cpu = ~clk_cpu;

  cpc_io_top cpc_io_top_i (.*);

  // Galois LFSR, one step per bit
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [7:0] wdata);
    int waited;
    waited = 0;
    @(negedge clk_cpu);
    {i_psel, i_penable, i_pwrite, i_paddr, i_pwdata} = {1'b1, 1'b0, wr, addr, wdata};
    @(negedge clk_cpu);
    i_penable = 1'b1;
    #2;  // Let pready settle
    while (!o_pready && waited < ACCESS_CYCLES) begin
      @(negedge clk_cpu);
      #2;
      waited++;
    end
    if (!o_pready) begin
      $display("Access to port %h never completed", addr);
      stall_errors++;
    end
    @(negedge clk_cpu);
    {i_psel, i_penable} = 2'b00;
  endtask

  // Read of PPI A, completes only once the queue drained
  task automatic drain();
    apb_access(1'b0, 16'hF400, 8'h00);
  endtask

  task automatic sweep_pens();
    for (int p = 0; p < 16; p++) begin
      @(negedge clk_cpu);
      i_pen = 4'(p);
    end
  endtask

  task automatic report_test(input string name);
    tests_done++;
    $display("Test %0d %s finished, assertion failures so far %0d", tests_done, name,
             cpc_io_top_i.cpc_io_assertions_i.fail_count);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_cpu);
    $display("Watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    {i_psel, i_penable, i_pwrite, i_paddr, i_pwdata, i_pen, i_mem_page} = '0;
    pwr_up_reset_n = 1'b0;
    repeat (3) @(posedge clk_cpu);
    @(negedge clk_cpu);
    pwr_up_reset_n = 1'b1;
    repeat (4) @(negedge clk_cpu);  // Idle, reset values and pready checked

    // ========================================================================
    // PPI readback
    // ========================================================================
    for (int i = 0; i < 12; i++) begin
      r  = take_bits(2);
      r2 = take_bits(8);
      r = (r[1:0] == 2'd0) ? 16'hF400 : (r[1:0] == 2'd1) ? 16'hF600 : 16'hF700;
      apb_access(1'b1, r, r2[7:0]);
      apb_access(1'b0, r, 8'h00);
    end
    report_test("ppi_readback");

    // Pen select then ink, then the border path
    for (int i = 0; i < 8; i++) begin
      r  = take_bits(4);
      r2 = take_bits(5);
      apb_access(1'b1, 16'h7F00, {4'b0000, r[3:0]});
      apb_access(1'b1, 16'h7F00, {3'b010, r2[4:0]});
      drain();
      sweep_pens();
    end
    r2 = take_bits(5);
    apb_access(1'b1, 16'h7F10, 8'h10);  // Border flag, pen kept
    apb_access(1'b1, 16'h7F00, {3'b010, r2[4:0]});
    drain();
    sweep_pens();
    report_test("palette_border");

    // ========================================================================
    // Mode, ROM disables, read source
    // ========================================================================
    for (int i = 0; i < 8; i++) begin
      r = take_bits(4);
      apb_access(1'b1, 16'h7F00, {4'b1000, r[3:0]});
      drain();
      for (int p = 0; p < 4; p++) begin
        @(negedge clk_cpu);
        i_mem_page = 2'(p);
      end
    end
    report_test("mode_read_source");

    for (int i = 0; i < 8; i++) begin
      r = take_bits(6);
      apb_access(1'b1, 16'h7F00, {2'b10, r[5:0]});  // D4 random
      apb_access(1'b1, 16'hDF00, {4'h0, r[3:0]});
      apb_access(1'b1, 16'h7F00, {2'b11, r[5:0]});
    end
    drain();
    report_test("int_clear");

    // Burst past the queue depth, no drains between
    for (int i = 0; i < 3 * cpc_io_pkg::QUEUE_DEPTH; i++) begin
      r = take_bits(8);
      apb_access(1'b1, (i % 3 == 0) ? 16'hDF00 : (i % 3 == 1) ? 16'h7F00 : 16'hF600,
                 (i % 3 == 1) ? {2'b11, r[5:0]} : r[7:0]);
    end
    drain();
    repeat (2) @(negedge clk_cpu);
    report_test("back_pressure");

    $display("Tests run %0d, assertion failures %0d, stalled accesses %0d", tests_done,
             cpc_io_top_i.cpc_io_assertions_i.fail_count, stall_errors);
    if (cpc_io_top_i.cpc_io_assertions_i.fail_count == 0 && stall_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
src/cpc_io_pkg.sv
src/cpc_ga_pkg.sv
src/io_cmd_if.sv
src/apb_io_decoder.sv
src/io_cmd_queue.sv
src/gate_array_regs.sv
src/cpc_io_top.sv
dv/cpc_io_assertions.sv
dv/cpc_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpc_io_tb
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
